// File: src.f
hw/mipsIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/hazardDetect.sv
hw/instrDecode.sv
hw/regFile.sv
hw/dataMem.sv
hw/mipsPipeCore.sv
sim/mipsPipeCoreTb.sv

// File: sim/coreStimulus.txt
// hex entries, sections end at ffffffffffff: program words, data words from address 0,
// then expected write-backs as {test index 2 digits, register 2 digits, value 8 digits}
// test 0: lw r1 r2, add, sub, and, or, slt, slt, sub, slt
8c010000 8c020004 00221820 00622022 00812824
00a33025 0046382a 00c7402a 00414822 0120502a
// test 1: sw r6 then lw r11 from the same word, add right behind the load
ac06000c 8c0b000c 01626020
// test 2: add then beq taken, lw then bne not taken, lw and add then bne taken, beq not taken
00206820 11a10001 0021a020 8c0e0004 15c20001 01c1a820
8c0f0000 00428020 15f00001 0021b020 120f0001 020fb820
// test 3: j and jal each over a marker add
0800001b 0021c020 00228820 0c00001e 0021c820 02219025
// test 4: lw of a pointer, lw through it, add of the second value
8c130008 8e7a0000 0353d820
// park on a jump to self
08000022
ffffffffffff
// data words 0 to 4
00000005 00000003 00000010 00000000 00000077
ffffffffffff
// test 0
000100000005 000200000003 000300000008 000400000005 000500000005
00060000000d 000700000001 000800000000 0009fffffffe 000a00000001
// test 1
010b0000000d 010c00000010
// test 2, r20 and r22 never written
020d00000005 020e00000003 021500000008 020f00000005 021000000006 02170000000b
// test 3, r24 and r25 never written
031100000008 03120000000d
// test 4
041300000010 041a00000077 041b00000087
ffffffffffff

// File: sim/mipsPipeCoreTb.sv
`timescale 1ns/1ps

module mipsPipeCoreTb;

	localparam int stimDepth = 128;
	localparam int imemWords = 256;
	localparam logic [47:0] endMark = 48'hffffffffffff;
	// extra cycles to catch a write-back beyond the expected list
	localparam int drainCycles = 8;

	logic        CLK;
	logic        rstN;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic        wbValid;
	logic [4:0]  wbReg;
	logic [31:0] wbData;

	logic [47:0] stim [stimDepth];
	logic [31:0] imem [imemWords];
	// {test index, register, value} in program order
	logic [47:0] expList [$];
	logic [47:0] entry;
	string testName [5] = '{"arith", "loadUse", "branch", "jump", "loadBase"};
	int progLen = 0;
	int timeoutLimit = 0;
	int cycleCount = 0;
	int errCount = 0;
	int testErrs = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int checks = 0;
	bit allSeen = 1'b0;

	mipsPipeCore #(.dataMemWords(64)) u_dut (
		.CLK(CLK), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	// fetch answers in the same cycle
	assign imemData = imem[imemAddr[9:2]];

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	initial begin
		int seed;
		int i;
		int d;
		seed = 8;
		rstN = 1'b0;
		void'($urandom(seed));
		// padding jumps to its own address, j or jal picked at random
		for (int w = 0; w < imemWords; w++)
			imem[w] = {6'h02 | 6'($urandom % 2), 26'(w)};
		for (int k = 0; k < stimDepth; k++)
			stim[k] = endMark;
		$readmemh("sim/coreStimulus.txt", stim);
		i = 0;
		while (i < stimDepth && stim[i] !== endMark) begin
			imem[i] = stim[i][31:0];
			i++;
		end
		progLen = i;
		i++;
		d = 0;
		// no immediate arithmetic in the subset, so constants start out in data memory
		while (i < stimDepth && stim[i] !== endMark) begin
			u_dut.u_dmem.mem[d] = stim[i][31:0];
			d++;
			i++;
		end
		i++;
		while (i < stimDepth && stim[i] !== endMark) begin
			expList.push_back(stim[i]);
			i++;
		end
		timeoutLimit = 5 * progLen + 40;
		repeat (3) @(posedge CLK);
		rstN <= 1'b1;
		wait (allSeen);
		repeat (drainCycles) @(negedge CLK);
		$display("tests passed %0d failed %0d, write-backs checked %0d, errors %0d",
			testsPassed, testsFailed, checks, errCount);
		if (errCount == 0 && testsFailed == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// each reported write against the next expected one
	always @(negedge CLK) begin
		if (rstN && wbValid) begin
			if (expList.size() == 0) begin
				$display("unexpected write-back of %h to r%0d after the last expected write",
					wbData, wbReg);
				errCount++;
			end else begin
				entry = expList.pop_front();
				checks++;
				if (wbReg != entry[36:32]) begin
					$display("[FAIL] %s: register expected r%0d actual r%0d",
						testName[entry[47:40]], entry[36:32], wbReg);
					testErrs++;
				end
				if (wbData != entry[31:0]) begin
					$display("[FAIL] %s: r%0d value expected %h actual %h",
						testName[entry[47:40]], entry[36:32], entry[31:0], wbData);
					testErrs++;
				end
				// last expected write of this test
				if (expList.size() == 0 || expList[0][47:40] != entry[47:40]) begin
					if (testErrs == 0) begin
						$display("test %s done, all writes match", testName[entry[47:40]]);
						testsPassed++;
					end else begin
						$display("test %s done with %0d errors", testName[entry[47:40]], testErrs);
						testsFailed++;
					end
					errCount += testErrs;
					testErrs = 0;
				end
				if (expList.size() == 0)
					allSeen = 1'b1;
			end
		end
	end

	// run length bound from the program size
	always @(negedge CLK) begin
		if (rstN) begin
			cycleCount++;
			if (cycleCount > timeoutLimit) begin
				$display("timeout after %0d cycles with %0d expected write-backs still missing",
					cycleCount, expList.size());
				$display("** FAIL **");
				$finish;
			end
		end
	end

endmodule

// File: hw/mipsPipeCore.sv
`timescale 1ns/1ps

module mipsPipeCore #(
	parameter int dataMemWords = 64
) (
	input  logic                              CLK,
	input  logic                              rstN,
	output logic [mipsIsaPkg::wordW-1:0]      imemAddr,
	input  logic [mipsIsaPkg::wordW-1:0]      imemData,
	output logic                              wbValid,
	output logic [mipsIsaPkg::regAddrW-1:0]   wbReg,
	output logic [mipsIsaPkg::wordW-1:0]      wbData
);

	localparam int aw = mipsIsaPkg::regAddrW;
	localparam int dw = mipsIsaPkg::wordW;

	// fetch and IF/ID
	logic [dw-1:0] pc, pcPlus4If, ifIdInstr, ifIdPcPlus4;
	// decode outputs
	mipsIsaPkg::opcodeE idOpcode;
	logic [aw-1:0] idRs, idRt, idDst;
	logic idRegWrite, idMemRead, idMemWrite, idAluSrcImm, branchTaken, jumpTaken;
	pipeCtrlPkg::aluOpE idAluOp;
	logic [dw-1:0] idImm, targetPc, rfRsData, rfRtData, idRsVal, idRtVal;
	logic pcWrite, ifIdWrite, idExBubble, ifFlush;
	// ID/EX
	mipsIsaPkg::opcodeE idExOpcode;
	logic idExRegWrite, idExMemRead, idExMemWrite, idExAluSrcImm;
	pipeCtrlPkg::aluOpE idExAluOp;
	logic [aw-1:0] idExRs, idExRt, idExDst;
	logic [dw-1:0] idExRsVal, idExRtVal, idExImm, fwdA, fwdB, aluB, aluOut;
	// EX/MEM
	mipsIsaPkg::opcodeE exMemOpcode;
	logic exMemRegWrite, exMemMemRead, exMemMemWrite, exMemFwdOk;
	logic [aw-1:0] exMemDst;
	logic [dw-1:0] exMemAluOut, exMemStoreData, memRdData;
	// MEM/WB
	mipsIsaPkg::opcodeE memWbOpcode;
	logic memWbRegWrite, memWbFwdOk;
	logic [aw-1:0] memWbDst;
	logic [dw-1:0] memWbResult;

	assign imemAddr  = pc;
	assign pcPlus4If = pc + 32'd4;

	always_ff @(posedge CLK) begin
		if (!rstN)
			pc <= '0;
		else if (pcWrite)
			pc <= (branchTaken || jumpTaken) ? targetPc : pcPlus4If;
	end

	// IF/ID, a flush turns the fetched word into a nop
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ifIdInstr <= '0;
		end else if (ifIdWrite) begin
			ifIdInstr   <= ifFlush ? '0 : imemData;
			ifIdPcPlus4 <= pcPlus4If;
		end
	end

	instrDecode u_decode (
		.instr(ifIdInstr), .pcPlus4(ifIdPcPlus4), .rsData(idRsVal), .rtData(idRtVal),
		.opcode(idOpcode), .rsAddr(idRs), .rtAddr(idRt), .dstReg(idDst),
		.regWrite(idRegWrite), .memRead(idMemRead), .memWrite(idMemWrite),
		.aluSrcImm(idAluSrcImm), .aluOp(idAluOp), .imm(idImm),
		.branchTaken(branchTaken), .jumpTaken(jumpTaken), .targetPc(targetPc)
	);

	regFile u_regs (
		.CLK(CLK), .rstN(rstN), .rdAddrA(idRs), .rdAddrB(idRt),
		.rdDataA(rfRsData), .rdDataB(rfRtData),
		.wrEn(memWbRegWrite), .wrAddr(memWbDst), .wrData(memWbResult)
	);

	// ALU results that may be forwarded (never loads, never r0)
	assign exMemFwdOk = exMemRegWrite && (exMemOpcode != mipsIsaPkg::opLw) && (exMemDst != '0);
	assign memWbFwdOk = memWbRegWrite && (memWbOpcode != mipsIsaPkg::opLw) && (memWbDst != '0);

	// branch comparator sees the memory-stage ALU result, so one bubble behind an R format
	assign idRsVal = (exMemFwdOk && (exMemDst == idRs)) ? exMemAluOut : rfRsData;
	assign idRtVal = (exMemFwdOk && (exMemDst == idRt)) ? exMemAluOut : rfRtData;

	hazardDetect u_hazard (
		.CLK(CLK), .rstN(rstN), .idOpcode(idOpcode), .idRs(idRs), .idRt(idRt),
		.exOpcode(idExOpcode), .exRegWrite(idExRegWrite), .exDst(idExDst),
		.memOpcode(exMemOpcode), .memRegWrite(exMemRegWrite), .memDst(exMemDst),
		.branchTaken(branchTaken), .jumpTaken(jumpTaken),
		.pcWrite(pcWrite), .ifIdWrite(ifIdWrite), .idExBubble(idExBubble),
		.ifFlush(ifFlush), .hazardCause()
	);

	// ID/EX, a bubble clears only the control bits
	always_ff @(posedge CLK) begin
		if (!rstN || idExBubble) begin
			idExOpcode   <= mipsIsaPkg::opRtype;
			idExRegWrite <= 1'b0;
			idExMemRead  <= 1'b0;
			idExMemWrite <= 1'b0;
		end else begin
			idExOpcode   <= idOpcode;
			idExRegWrite <= idRegWrite;
			idExMemRead  <= idMemRead;
			idExMemWrite <= idMemWrite;
		end
		idExAluSrcImm <= idAluSrcImm;
		idExAluOp     <= idAluOp;
		idExRs        <= idRs;
		idExRt        <= idRt;
		idExDst       <= idDst;
		idExRsVal     <= idRsVal;
		idExRtVal     <= idRtVal;
		idExImm       <= idImm;
	end

	// forwarding, memory stage wins over write-back
	assign fwdA = (exMemFwdOk && (exMemDst == idExRs)) ? exMemAluOut
		: (memWbFwdOk && (memWbDst == idExRs)) ? memWbResult : idExRsVal;
	assign fwdB = (exMemFwdOk && (exMemDst == idExRt)) ? exMemAluOut
		: (memWbFwdOk && (memWbDst == idExRt)) ? memWbResult : idExRtVal;
	assign aluB = idExAluSrcImm ? idExImm : fwdB;

	always_comb begin
		case (idExAluOp)
			pipeCtrlPkg::aluSub: aluOut = fwdA - aluB;
			pipeCtrlPkg::aluAnd: aluOut = fwdA & aluB;
			pipeCtrlPkg::aluOr:  aluOut = fwdA | aluB;
			pipeCtrlPkg::aluSlt: aluOut = {31'd0, $signed(fwdA) < $signed(aluB)};
			default:             aluOut = fwdA + aluB;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			exMemOpcode   <= mipsIsaPkg::opRtype;
			exMemRegWrite <= 1'b0;
			exMemMemRead  <= 1'b0;
			exMemMemWrite <= 1'b0;
		end else begin
			exMemOpcode   <= idExOpcode;
			exMemRegWrite <= idExRegWrite;
			exMemMemRead  <= idExMemRead;
			exMemMemWrite <= idExMemWrite;
		end
		exMemDst       <= idExDst;
		exMemAluOut    <= aluOut;
		// store data is the forwarded rt, not the immediate
		exMemStoreData <= fwdB;
	end

	dataMem #(.dataMemWords(dataMemWords)) u_dmem (
		.CLK(CLK), .addr(exMemAluOut), .wrEn(exMemMemWrite),
		.wrData(exMemStoreData), .rdData(memRdData)
	);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			memWbOpcode   <= mipsIsaPkg::opRtype;
			memWbRegWrite <= 1'b0;
		end else begin
			memWbOpcode   <= exMemOpcode;
			memWbRegWrite <= exMemRegWrite;
		end
		memWbDst    <= exMemDst;
		memWbResult <= exMemMemRead ? memRdData : exMemAluOut;
	end

	// report every architectural register write
	assign wbValid = memWbRegWrite && (memWbDst != '0);
	assign wbReg   = memWbDst;
	assign wbData  = memWbResult;

endmodule

// File: hw/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
	parameter int dataMemWords = 64
) (
	input  logic                           CLK,
	input  logic [mipsIsaPkg::wordW-1:0]   addr,
	input  logic                           wrEn,
	input  logic [mipsIsaPkg::wordW-1:0]   wrData,
	output logic [mipsIsaPkg::wordW-1:0]   rdData
);

	localparam int idxW = $clog2(dataMemWords);

	logic [mipsIsaPkg::wordW-1:0] mem [dataMemWords];
	logic [idxW-1:0]              wordIdx;

	// byte address to word index, wrapping at the depth
	assign wordIdx = idxW'((addr >> 2) % dataMemWords);

	always_ff @(posedge CLK) begin
		if (wrEn)
			mem[wordIdx] <= wrData;
	end

	assign rdData = mem[wordIdx];

	// only whole aligned words are stored
	alignedStore: assert property (@(posedge CLK) wrEn |-> (addr[1:0] == 2'b00));

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                              CLK,
	input  logic                              rstN,
	input  logic [mipsIsaPkg::regAddrW-1:0]   rdAddrA,
	input  logic [mipsIsaPkg::regAddrW-1:0]   rdAddrB,
	output logic [mipsIsaPkg::wordW-1:0]      rdDataA,
	output logic [mipsIsaPkg::wordW-1:0]      rdDataB,
	input  logic                              wrEn,
	input  logic [mipsIsaPkg::regAddrW-1:0]   wrAddr,
	input  logic [mipsIsaPkg::wordW-1:0]      wrData
);

	localparam int numRegs = 1 << mipsIsaPkg::regAddrW;

	logic [mipsIsaPkg::wordW-1:0] regs [numRegs];

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++)
				regs[i] <= '0;
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// r0 reads zero; a same-cycle write is passed straight through
	assign rdDataA = (rdAddrA == '0) ? '0
		: (wrEn && (wrAddr == rdAddrA)) ? wrData
		: regs[rdAddrA];

	assign rdDataB = (rdAddrB == '0) ? '0
		: (wrEn && (wrAddr == rdAddrB)) ? wrData
		: regs[rdAddrB];

endmodule

// File: hw/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  logic [mipsIsaPkg::wordW-1:0]      instr,
	input  logic [mipsIsaPkg::wordW-1:0]      pcPlus4,
	input  logic [mipsIsaPkg::wordW-1:0]      rsData,
	input  logic [mipsIsaPkg::wordW-1:0]      rtData,
	output mipsIsaPkg::opcodeE                opcode,
	output logic [mipsIsaPkg::regAddrW-1:0]   rsAddr,
	output logic [mipsIsaPkg::regAddrW-1:0]   rtAddr,
	output logic [mipsIsaPkg::regAddrW-1:0]   dstReg,
	output logic                              regWrite,
	output logic                              memRead,
	output logic                              memWrite,
	output logic                              aluSrcImm,
	output pipeCtrlPkg::aluOpE                aluOp,
	output logic [mipsIsaPkg::wordW-1:0]      imm,
	output logic                              branchTaken,
	output logic                              jumpTaken,
	output logic [mipsIsaPkg::wordW-1:0]      targetPc
);

	logic [mipsIsaPkg::opcodeW-1:0]  opField;
	logic [mipsIsaPkg::functW-1:0]   fnField;
	logic [mipsIsaPkg::regAddrW-1:0] rdField;

	assign opField = instr[mipsIsaPkg::wordW-1 -: mipsIsaPkg::opcodeW];
	assign fnField = instr[mipsIsaPkg::functW-1:0];
	assign rdField = instr[mipsIsaPkg::rdLsb +: mipsIsaPkg::regAddrW];

	// sign extended offset, shared by lw/sw and branches
	assign imm = {{(mipsIsaPkg::wordW - mipsIsaPkg::immW){instr[mipsIsaPkg::immW-1]}},
		instr[mipsIsaPkg::immW-1:0]};

	// jump keeps the upper nibble of pc+4; branch is relative to pc+4
	assign targetPc = jumpTaken
		? {pcPlus4[31:28], instr[mipsIsaPkg::jumpIdxW-1:0], 2'b00}
		: pcPlus4 + {imm[mipsIsaPkg::wordW-3:0], 2'b00};

	always_comb begin
		// defaults describe a nop
		opcode      = mipsIsaPkg::opRtype;
		rsAddr      = instr[mipsIsaPkg::rsLsb +: mipsIsaPkg::regAddrW];
		rtAddr      = instr[mipsIsaPkg::rtLsb +: mipsIsaPkg::regAddrW];
		dstReg      = '0;
		regWrite    = 1'b0;
		memRead     = 1'b0;
		memWrite    = 1'b0;
		aluSrcImm   = 1'b0;
		aluOp       = pipeCtrlPkg::aluAdd;
		branchTaken = 1'b0;
		jumpTaken   = 1'b0;
		case (opField)
			mipsIsaPkg::opRtype: begin
				dstReg = rdField;
				// unknown funct (including the all-zero nop) writes nothing
				regWrite = 1'b1;
				case (fnField)
					mipsIsaPkg::fnAdd: aluOp = pipeCtrlPkg::aluAdd;
					mipsIsaPkg::fnSub: aluOp = pipeCtrlPkg::aluSub;
					mipsIsaPkg::fnAnd: aluOp = pipeCtrlPkg::aluAnd;
					mipsIsaPkg::fnOr:  aluOp = pipeCtrlPkg::aluOr;
					mipsIsaPkg::fnSlt: aluOp = pipeCtrlPkg::aluSlt;
					default:           regWrite = 1'b0;
				endcase
			end
			mipsIsaPkg::opLw: begin
				opcode    = mipsIsaPkg::opLw;
				dstReg    = rtAddr;
				regWrite  = 1'b1;
				memRead   = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsIsaPkg::opSw: begin
				opcode    = mipsIsaPkg::opSw;
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsIsaPkg::opBeq: begin
				opcode      = mipsIsaPkg::opBeq;
				branchTaken = (rsData == rtData);
			end
			mipsIsaPkg::opBne: begin
				opcode      = mipsIsaPkg::opBne;
				branchTaken = (rsData != rtData);
			end
			mipsIsaPkg::opJ, mipsIsaPkg::opJal: begin
				// jal behaves as j, r31 is not written
				opcode    = (opField == mipsIsaPkg::opJal) ? mipsIsaPkg::opJal : mipsIsaPkg::opJ;
				jumpTaken = 1'b1;
				rsAddr    = '0;
				rtAddr    = '0;
			end
			default: begin
				// unsupported opcode, no sources so no false stalls
				rsAddr = '0;
				rtAddr = '0;
			end
		endcase
	end

	// a single instruction cannot both load and store
	always_comb begin
		memAccessExclusive: assert final (!(memRead && memWrite))
			else $error("lw and sw decoded together for %h", instr);
	end

endmodule

// File: hw/hazardDetect.sv
`timescale 1ns/1ps

module hazardDetect (
	input  logic                              CLK,
	input  logic                              rstN,
	input  mipsIsaPkg::opcodeE                idOpcode,
	input  logic [mipsIsaPkg::regAddrW-1:0]   idRs,
	input  logic [mipsIsaPkg::regAddrW-1:0]   idRt,
	input  mipsIsaPkg::opcodeE                exOpcode,
	input  logic                              exRegWrite,
	input  logic [mipsIsaPkg::regAddrW-1:0]   exDst,
	input  mipsIsaPkg::opcodeE                memOpcode,
	input  logic                              memRegWrite,
	input  logic [mipsIsaPkg::regAddrW-1:0]   memDst,
	input  logic                              branchTaken,
	input  logic                              jumpTaken,
	output logic                              pcWrite,
	output logic                              ifIdWrite,
	output logic                              idExBubble,
	output logic                              ifFlush,
	output pipeCtrlPkg::hazardCauseE          hazardCause
);

	// instruction classes in decode
	logic idBranch, idRtype, idMem;
	// producers further down the pipe that write a nonzero register
	logic exAlu, exLoad, memLoad;
	// individual hazard conditions
	logic brAlu, brLoadEx, brLoadMem, useLoadEx, useLoadMem;
	logic stall;

	assign idBranch = (idOpcode == mipsIsaPkg::opBeq) || (idOpcode == mipsIsaPkg::opBne);
	assign idRtype  = (idOpcode == mipsIsaPkg::opRtype);
	assign idMem    = (idOpcode == mipsIsaPkg::opLw) || (idOpcode == mipsIsaPkg::opSw);

	assign exAlu   = exRegWrite && (exOpcode == mipsIsaPkg::opRtype) && (exDst != '0);
	assign exLoad  = exRegWrite && (exOpcode == mipsIsaPkg::opLw) && (exDst != '0);
	assign memLoad = memRegWrite && (memOpcode == mipsIsaPkg::opLw) && (memDst != '0);

	// branch compares in decode, so both sources must be final
	assign brAlu     = idBranch && exAlu && ((exDst == idRs) || (exDst == idRt));
	assign brLoadEx  = idBranch && exLoad && ((exDst == idRs) || (exDst == idRt));
	assign brLoadMem = idBranch && memLoad && ((memDst == idRs) || (memDst == idRt));

	// loads are never forwarded; wait until the load sits in write-back
	// lw and sw only depend on the base register
	assign useLoadEx  = (idRtype && exLoad && ((exDst == idRs) || (exDst == idRt)))
		|| (idMem && exLoad && (exDst == idRs));
	assign useLoadMem = (idRtype && memLoad && ((memDst == idRs) || (memDst == idRt)))
		|| (idMem && memLoad && (memDst == idRs));

	assign stall = brAlu || brLoadEx || brLoadMem || useLoadEx || useLoadMem;

	// hold PC and IF/ID, push a nop into execute
	assign pcWrite    = !stall;
	assign ifIdWrite  = !stall;
	assign idExBubble = stall;
	// a stalled branch has stale operands, so no flush yet
	assign ifFlush    = !stall && (branchTaken || jumpTaken);

	always_comb begin
		if (brAlu)
			hazardCause = pipeCtrlPkg::hzBranchAlu;
		else if (brLoadEx)
			hazardCause = pipeCtrlPkg::hzBranchLoadEx;
		else if (brLoadMem)
			hazardCause = pipeCtrlPkg::hzBranchLoadMem;
		else if (useLoadEx)
			hazardCause = pipeCtrlPkg::hzLoadUseEx;
		else if (useLoadMem)
			hazardCause = pipeCtrlPkg::hzLoadUseMem;
		else
			hazardCause = pipeCtrlPkg::hzNone;
	end

	// a flushed slot decodes as a nop with no sources and cannot stall
	flushThenNoBubble: assert property (@(posedge CLK) disable iff (!rstN)
		ifFlush |=> !idExBubble);

	// one bubble moves the load from execute to memory while decode still waits
	loadStallAdvances: assert property (@(posedge CLK) disable iff (!rstN)
		(hazardCause == pipeCtrlPkg::hzLoadUseEx)
			|=> (hazardCause == pipeCtrlPkg::hzLoadUseMem));

endmodule

// File: hw/pipeCtrlPkg.sv
package pipeCtrlPkg;

	// operation selected for the execute ALU
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpE;

	// reason for the current stall, highest priority first
	typedef enum logic [2:0] {
		hzNone          = 3'd0,
		// R format in execute feeds a branch in decode
		hzBranchAlu     = 3'd1,
		// load in execute feeds a branch
		hzBranchLoadEx  = 3'd2,
		// load in memory feeds a branch
		hzBranchLoadMem = 3'd3,
		// load in execute feeds an ALU or address operand
		hzLoadUseEx     = 3'd4,
		// load in memory feeds an ALU or address operand
		hzLoadUseMem    = 3'd5
	} hazardCauseE;

endpackage

// File: hw/mipsIsaPkg.sv
package mipsIsaPkg;

	// datapath and register index widths
	localparam int wordW = 32;
	localparam int regAddrW = 5;

	// instruction field widths
	localparam int opcodeW = 6;
	localparam int functW = 6;
	localparam int immW = 16;
	localparam int jumpIdxW = 26;

	// low bit of each register field in the word
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;

	// primary opcodes of the supported subset
	typedef enum logic [opcodeW-1:0] {
		opRtype = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opBne   = 6'h05,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeE;

	// funct field for R format
	typedef enum logic [functW-1:0] {
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functE;

endpackage
